//--- src/dll_pkg.sv
package dll_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    localparam int pipe_width   = 256;
    localparam int dllp_width   = 48;    // token/crc, type and three payload bytes
    localparam int token_width  = 16;
    localparam int crc_width    = 16;
    localparam int seq_width    = 12;
    localparam int credit_width = 12;

    localparam logic [token_width-1:0] dllp_token = 16'hACF0;
    localparam logic [crc_width-1:0]   crc_poly   = 16'h100B;
    localparam logic [crc_width-1:0]   crc_seed   = 16'hFFFF;

    // ----------------------------------------------------------------------
    // bit positions inside a dllp beat
    // ----------------------------------------------------------------------
    localparam int crc_in_msb  = 47;     // crc runs msb first
    localparam int crc_in_lsb  = 16;
    localparam int type_msb    = 23;
    localparam int type_lsb    = 16;
    localparam int hdr_hi_msb  = 29;
    localparam int hdr_hi_lsb  = 24;
    localparam int hdr_lo_msb  = 39;
    localparam int hdr_lo_lsb  = 38;
    localparam int data_hi_msb = 35;
    localparam int data_hi_lsb = 32;
    localparam int data_lo_msb = 47;
    localparam int data_lo_lsb = 40;

    typedef logic [pipe_width-1:0]   pipe_data_t;
    typedef logic [seq_width-1:0]    seq_num_t;
    typedef logic [credit_width-1:0] credit_t;

    typedef enum logic [7:0] {
        dllp_ack       = 8'h00,
        dllp_nak       = 8'h10,
        dllp_init1_p   = 8'h40,
        dllp_init1_np  = 8'h50,
        dllp_init1_cpl = 8'h60,
        dllp_updfc_p   = 8'h80,
        dllp_updfc_np  = 8'h90,
        dllp_updfc_cpl = 8'hA0,
        dllp_init2_p   = 8'hC0,
        dllp_init2_np  = 8'hD0,
        dllp_init2_cpl = 8'hE0
    } dllp_type_e;

    typedef enum logic [1:0] {
        acknak_none = 2'd0,
        acknak_ack  = 2'd1,
        acknak_nak  = 2'd2
    } acknak_e;

endpackage

//--- src/tlp_pkg.sv
package tlp_pkg;

    // ----------------------------------------------------------------------
    // header-only non-posted tlp layout
    // ----------------------------------------------------------------------
    localparam int          np_marker_msb = 3;
    localparam logic [3:0]  np_marker     = 4'b1111;   // low nibble of the beat

    localparam int seq_hi_msb = 19;    // seq = {19:16, 31:24}
    localparam int seq_hi_lsb = 16;
    localparam int seq_lo_msb = 31;
    localparam int seq_lo_lsb = 24;
    localparam int np_hdr_msb = 159;   // forwarded header, 128 bits
    localparam int np_hdr_lsb = 32;

    // codes toward the transaction layer
    typedef enum logic [2:0] {
        tl_idle   = 3'd0,
        tl_np_hdr = 3'd3,
        tl_done   = 3'd7
    } tl_code_e;

    typedef enum logic [1:0] {
        st_idle,
        st_seq_check,
        st_send_hdr,
        st_done
    } tlp_state_e;

endpackage

//--- src/dllp_if.sv
interface dllp_if
    import dll_pkg::*;
();

    logic       valid;         // one pulse per dllp that passed crc
    dllp_type_e dllp_type;
    credit_t    hdr_field;
    credit_t    data_field;    // also the ack/nak sequence number

    modport framer (
        output valid,
        output dllp_type,
        output hdr_field,
        output data_field
    );

    modport decoder (
        input  valid,
        input  dllp_type,
        input  hdr_field,
        input  data_field
    );

endinterface

//--- src/rx_framer.sv
module rx_framer
    import dll_pkg::*;
    import tlp_pkg::*;
(
    input  logic          sclk_i,
    input  logic          srst_n_i,
    input  logic          pipe_valid_i,
    input  pipe_data_t    pipe_data_i,
    output logic          tlp_start_o,
    dllp_if.framer        dllp
);

    logic                  is_dllp;
    logic                  s1_valid;
    logic [dllp_width-1:0] s1_dllp;
    logic [crc_width-1:0]  crc;
    logic                  crc_ok;

    assign is_dllp     = pipe_valid_i && (pipe_data_i[token_width-1:0] == dllp_token);
    assign tlp_start_o = pipe_valid_i && !is_dllp &&
                         (pipe_data_i[np_marker_msb:0] == np_marker);

    // ----------------------------------------------------------------------
    // stage 1, capture the dllp bytes
    // ----------------------------------------------------------------------
    always_ff @(posedge sclk_i) begin
        if (!srst_n_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= is_dllp;
        end
    end

    always_ff @(posedge sclk_i) begin
        if (is_dllp) begin
            s1_dllp <= pipe_data_i[dllp_width-1:0];
        end
    end

    // bit-serial crc-16 over the 32 payload bits
    always_comb begin
        crc = crc_seed;
        for (int i = crc_in_msb; i >= crc_in_lsb; i--) begin
            if (crc[crc_width-1] ^ s1_dllp[i]) begin
                crc = {crc[crc_width-2:0], 1'b0} ^ crc_poly;
            end else begin
                crc = {crc[crc_width-2:0], 1'b0};
            end
        end
    end

    assign crc_ok = (s1_dllp[crc_width-1:0] == ~crc);

    // ----------------------------------------------------------------------
    // stage 2, hand over checked dllps
    // ----------------------------------------------------------------------
    always_ff @(posedge sclk_i) begin
        if (!srst_n_i) begin
            dllp.valid <= 1'b0;
        end else begin
            dllp.valid <= s1_valid && crc_ok;   // bad crc simply drops out
        end
    end

    always_ff @(posedge sclk_i) begin
        dllp.dllp_type  <= dllp_type_e'(s1_dllp[type_msb:type_lsb]);
        dllp.hdr_field  <= credit_t'({s1_dllp[hdr_hi_msb:hdr_hi_lsb],
                                      s1_dllp[hdr_lo_msb:hdr_lo_lsb]});
        dllp.data_field <= {s1_dllp[data_hi_msb:data_hi_lsb], s1_dllp[data_lo_msb:data_lo_lsb]};
    end

    a_no_valid_after_reset: assert property (
        @(posedge sclk_i) $rose(srst_n_i) |=> !dllp.valid    // stage 1 leaves reset empty
    );

endmodule

//--- src/dllp_decoder.sv
module dllp_decoder
    import dll_pkg::*;
(
    input  logic     sclk_i,
    input  logic     srst_n_i,
    dllp_if.decoder  dllp,
    output logic     init1_received_o,
    output logic     init2_received_o,
    output seq_num_t acknak_seq_num_o,
    output acknak_e  acknak_seq_en_o,
    output credit_t  cc_p_h_o,
    output credit_t  cc_p_d_o,
    output credit_t  cc_np_h_o,
    output credit_t  cc_cpl_h_o,
    output credit_t  cc_cpl_d_o,
    output logic     cc_p_en_o,
    output logic     cc_np_en_o,
    output logic     cc_cpl_en_o,
    output credit_t  cl_p_h_o,
    output credit_t  cl_p_d_o,
    output credit_t  cl_np_h_o,
    output credit_t  cl_cpl_h_o,
    output credit_t  cl_cpl_d_o
);

    logic [2:0] init1_seen;   // {cpl, np, p}
    logic [2:0] init2_seen;

    assign init1_received_o = &init1_seen;
    assign init2_received_o = &init2_seen;

    always_ff @(posedge sclk_i) begin
        if (!srst_n_i) begin
            init1_seen       <= '0;
            init2_seen       <= '0;
            acknak_seq_num_o <= '0;
            acknak_seq_en_o  <= acknak_none;
            cc_p_h_o         <= '0;
            cc_p_d_o         <= '0;
            cc_np_h_o        <= '0;
            cc_cpl_h_o       <= '0;
            cc_cpl_d_o       <= '0;
            cc_p_en_o        <= 1'b0;
            cc_np_en_o       <= 1'b0;
            cc_cpl_en_o      <= 1'b0;
            cl_p_h_o         <= '0;
            cl_p_d_o         <= '0;
            cl_np_h_o        <= '0;
            cl_cpl_h_o       <= '0;
            cl_cpl_d_o       <= '0;
        end else begin
            acknak_seq_en_o <= acknak_none;    // pulses by default
            cc_p_en_o       <= 1'b0;
            cc_np_en_o      <= 1'b0;
            cc_cpl_en_o     <= 1'b0;
            if (dllp.valid) begin
                case (dllp.dllp_type)
                    dllp_ack: begin
                        acknak_seq_en_o  <= acknak_ack;
                        acknak_seq_num_o <= seq_num_t'(dllp.data_field);
                    end
                    dllp_nak: begin
                        acknak_seq_en_o  <= acknak_nak;
                        acknak_seq_num_o <= seq_num_t'(dllp.data_field);
                    end
                    dllp_init1_p: begin
                        cl_p_h_o      <= dllp.hdr_field;
                        cl_p_d_o      <= dllp.data_field;
                        cc_p_en_o     <= 1'b1;
                        init1_seen[0] <= 1'b1;
                    end
                    dllp_init1_np: begin
                        cl_np_h_o     <= dllp.hdr_field;
                        cc_np_en_o    <= 1'b1;
                        init1_seen[1] <= 1'b1;
                    end
                    dllp_init1_cpl: begin
                        cl_cpl_h_o    <= dllp.hdr_field;
                        cl_cpl_d_o    <= dllp.data_field;
                        cc_cpl_en_o   <= 1'b1;
                        init1_seen[2] <= 1'b1;
                    end
                    dllp_init2_p:   init2_seen[0] <= 1'b1;
                    dllp_init2_np:  init2_seen[1] <= 1'b1;
                    dllp_init2_cpl: init2_seen[2] <= 1'b1;
                    dllp_updfc_p: begin
                        cc_p_h_o <= dllp.hdr_field;
                        cc_p_d_o <= dllp.data_field;
                    end
                    dllp_updfc_np:  cc_np_h_o <= dllp.hdr_field;
                    dllp_updfc_cpl: begin
                        cc_cpl_h_o <= dllp.hdr_field;
                        cc_cpl_d_o <= dllp.data_field;
                    end
                    default: ;                 // unknown type, nothing changes
                endcase
            end
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    a_acknak_code: assert property (
        @(posedge sclk_i) disable iff (!srst_n_i) 2'(acknak_seq_en_o) != 2'b11
    );

    // a pulse only lasts past one cycle when another dllp was already behind it
    property p_pulse_ends(en);
        @(posedge sclk_i) disable iff (!srst_n_i) (en && !dllp.valid) |=> !en;
    endproperty

    a_cc_p_pulse:   assert property (p_pulse_ends(cc_p_en_o));
    a_cc_np_pulse:  assert property (p_pulse_ends(cc_np_en_o));
    a_cc_cpl_pulse: assert property (p_pulse_ends(cc_cpl_en_o));

endmodule

//--- src/tlp_seq_check.sv
module tlp_seq_check
    import dll_pkg::*;
    import tlp_pkg::*;
(
    input  logic       sclk_i,
    input  logic       srst_n_i,
    input  logic       tlp_start_i,
    input  pipe_data_t pipe_data_i,
    output seq_num_t   next_rcv_seq_o,
    output logic       nak_scheduled_o,
    output pipe_data_t dll2tl_data_o,
    output tl_code_e   dll2tl_data_en_o
);

    tlp_state_e state;
    pipe_data_t tlp_beat;
    seq_num_t   rx_seq;

    assign rx_seq = {tlp_beat[seq_hi_msb:seq_hi_lsb], tlp_beat[seq_lo_msb:seq_lo_lsb]};

    always_ff @(posedge sclk_i) begin
        if (state == st_idle && tlp_start_i) begin
            tlp_beat <= pipe_data_i;    // only taken while idle
        end
    end

    // ----------------------------------------------------------------------
    // sequence check and header forwarding
    // ----------------------------------------------------------------------
    always_ff @(posedge sclk_i) begin
        if (!srst_n_i) begin
            state            <= st_idle;
            next_rcv_seq_o   <= '0;
            nak_scheduled_o  <= 1'b0;
            dll2tl_data_o    <= '0;
            dll2tl_data_en_o <= tl_idle;
        end else begin
            case (state)
                st_idle: begin
                    dll2tl_data_en_o <= tl_idle;
                    if (tlp_start_i) begin
                        state <= st_seq_check;
                    end
                end
                st_seq_check: begin
                    if (rx_seq == next_rcv_seq_o) begin
                        next_rcv_seq_o  <= next_rcv_seq_o + seq_num_t'(1);  // wraps at 4096
                        nak_scheduled_o <= 1'b0;
                        state           <= st_send_hdr;
                    end else begin
                        nak_scheduled_o <= 1'b1;    // out of order, drop it
                        state           <= st_idle;
                    end
                end
                st_send_hdr: begin
                    dll2tl_data_o    <= pipe_data_t'(tlp_beat[np_hdr_msb:np_hdr_lsb]);
                    dll2tl_data_en_o <= tl_np_hdr;
                    state            <= st_done;
                end
                st_done: begin
                    dll2tl_data_en_o <= tl_done;
                    state            <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_done_after_hdr: assert property (
        @(posedge sclk_i) disable iff (!srst_n_i)
        dll2tl_data_en_o == tl_np_hdr |=> dll2tl_data_en_o == tl_done
    );

endmodule

//--- src/dll_rx.sv
module dll_rx
    import dll_pkg::*;
    import tlp_pkg::*;
(
    input  logic       sclk_i,
    input  logic       srst_n_i,
    // ----------------------------------------------------------------------
    // pipe side
    // ----------------------------------------------------------------------
    input  logic       pipe_valid_i,
    input  pipe_data_t pipe_data_i,
    // ----------------------------------------------------------------------
    // link state, ack/nak and transaction layer
    // ----------------------------------------------------------------------
    output logic       init1_received_o,
    output logic       init2_received_o,
    output logic       nak_scheduled_o,
    output seq_num_t   next_rcv_seq_o,
    output seq_num_t   acknak_seq_num_o,
    output acknak_e    acknak_seq_en_o,
    output pipe_data_t dll2tl_data_o,
    output tl_code_e   dll2tl_data_en_o,
    // ----------------------------------------------------------------------
    // flow control credits of the link partner
    // ----------------------------------------------------------------------
    output credit_t    cc_p_h_o,
    output credit_t    cc_p_d_o,
    output credit_t    cc_np_h_o,
    output credit_t    cc_cpl_h_o,
    output credit_t    cc_cpl_d_o,
    output logic       cc_p_en_o,
    output logic       cc_np_en_o,
    output logic       cc_cpl_en_o,
    output credit_t    cl_p_h_o,
    output credit_t    cl_p_d_o,
    output credit_t    cl_np_h_o,
    output credit_t    cl_cpl_h_o,
    output credit_t    cl_cpl_d_o
);

    logic tlp_start;    // header-only np tlp on the input

    dllp_if i_dllp_if ();

    rx_framer i_rx_framer (
        .sclk_i       (sclk_i),
        .srst_n_i     (srst_n_i),
        .pipe_valid_i (pipe_valid_i),
        .pipe_data_i  (pipe_data_i),
        .tlp_start_o  (tlp_start),
        .dllp         (i_dllp_if.framer)
    );

    dllp_decoder i_dllp_decoder (
        .sclk_i           (sclk_i),
        .srst_n_i         (srst_n_i),
        .dllp             (i_dllp_if.decoder),
        .init1_received_o (init1_received_o),
        .init2_received_o (init2_received_o),
        .acknak_seq_num_o (acknak_seq_num_o),
        .acknak_seq_en_o  (acknak_seq_en_o),
        .cc_p_h_o         (cc_p_h_o),
        .cc_p_d_o         (cc_p_d_o),
        .cc_np_h_o        (cc_np_h_o),
        .cc_cpl_h_o       (cc_cpl_h_o),
        .cc_cpl_d_o       (cc_cpl_d_o),
        .cc_p_en_o        (cc_p_en_o),
        .cc_np_en_o       (cc_np_en_o),
        .cc_cpl_en_o      (cc_cpl_en_o),
        .cl_p_h_o         (cl_p_h_o),
        .cl_p_d_o         (cl_p_d_o),
        .cl_np_h_o        (cl_np_h_o),
        .cl_cpl_h_o       (cl_cpl_h_o),
        .cl_cpl_d_o       (cl_cpl_d_o)
    );

    tlp_seq_check i_tlp_seq_check (
        .sclk_i           (sclk_i),
        .srst_n_i         (srst_n_i),
        .tlp_start_i      (tlp_start),
        .pipe_data_i      (pipe_data_i),
        .next_rcv_seq_o   (next_rcv_seq_o),
        .nak_scheduled_o  (nak_scheduled_o),
        .dll2tl_data_o    (dll2tl_data_o),
        .dll2tl_data_en_o (dll2tl_data_en_o)
    );

endmodule

//--- bench/dll_rx_tb.sv
module dll_rx_tb
    import dll_pkg::*;
    import tlp_pkg::*;
();

    typedef struct packed {
        acknak_e     an_en;
        seq_num_t    an_num;
        logic [2:0]  cc_en;      // {p, np, cpl}
        logic [59:0] cl;         // {p_h, p_d, np_h, cpl_h, cpl_d}
        logic [59:0] cc;
        logic [1:0]  init;       // {init1, init2}
    } dllp_exp_t;

    typedef struct packed {
        seq_num_t   next_seq;
        logic       nak;
        logic       fwd;         // this beat should come out as np header
        pipe_data_t data;
    } tlp_exp_t;

    logic       sclk;
    logic       srst_n;
    logic       pipe_valid;
    pipe_data_t pipe_data;
    logic       init1_received_o, init2_received_o, nak_scheduled_o;
    seq_num_t   next_rcv_seq_o, acknak_seq_num_o;
    acknak_e    acknak_seq_en_o;
    pipe_data_t dll2tl_data_o;
    tl_code_e   dll2tl_data_en_o;
    credit_t    cc_p_h_o, cc_p_d_o, cc_np_h_o, cc_cpl_h_o, cc_cpl_d_o;
    credit_t    cl_p_h_o, cl_p_d_o, cl_np_h_o, cl_cpl_h_o, cl_cpl_d_o;
    logic       cc_p_en_o, cc_np_en_o, cc_cpl_en_o;

    dllp_exp_t  exp_dllp = '0;   // model, updated when a beat is driven
    tlp_exp_t   exp_tlp = '0;
    dllp_exp_t  dllp_q [1:3];    // model delayed to the dut latency
    tlp_exp_t   tlp_q [1:4];
    logic [2:0] seen1 = '0;
    logic [2:0] seen2 = '0;
    logic [59:0] cl_all, cc_all;
    tl_code_e   want_code;
    int         errors = 0;
    int         cycles = 0;

    assign cl_all    = {cl_p_h_o, cl_p_d_o, cl_np_h_o, cl_cpl_h_o, cl_cpl_d_o};
    assign cc_all    = {cc_p_h_o, cc_p_d_o, cc_np_h_o, cc_cpl_h_o, cc_cpl_d_o};
    assign want_code = tlp_q[3].fwd ? tl_np_hdr : (tlp_q[4].fwd ? tl_done : tl_idle);

    dll_rx i_dll_rx (
        .sclk_i       (sclk),
        .srst_n_i     (srst_n),
        .pipe_valid_i (pipe_valid),
        .pipe_data_i  (pipe_data),
        .*
    );

    initial sclk = 1'b0;
    always #50 sclk = ~sclk;

    always @(posedge sclk) begin
        dllp_q[1] <= exp_dllp;
        dllp_q[2] <= dllp_q[1];
        dllp_q[3] <= dllp_q[2];
        tlp_q[1]  <= exp_tlp;
        tlp_q[2]  <= tlp_q[1];
        tlp_q[3]  <= tlp_q[2];
        tlp_q[4]  <= tlp_q[3];
    end

    // ----------------------------------------------------------------------
    // reference model helpers
    // ----------------------------------------------------------------------
    function automatic logic [15:0] dllp_crc(input logic [31:0] msg);
        logic [15:0] crc;
        logic        fb;
        crc = crc_seed;
        for (int i = 31; i >= 0; i--) begin   // bit 47 of the beat first
            fb  = crc[15] ^ msg[i];
            crc = crc << 1;
            if (fb) begin
                crc = crc ^ crc_poly;
            end
        end
        return ~crc;
    endfunction

    // the token doubles as crc, so search random fields until the crc hits it
    function automatic pipe_data_t build_dllp(input dllp_type_e kind, output logic [7:0] hdr,
                                              output credit_t data);
        pipe_data_t beat;
        logic [3:0] spare;
        beat = '0;
        for (int n = 0; n < 4000000; n++) begin
            hdr   = 8'($urandom);
            data  = 12'($urandom);
            spare = 4'($urandom);
            beat[47:16] = {data[7:0], hdr[1:0], spare[3:2], data[11:8], spare[1:0],
                           hdr[7:2], kind};
            if (dllp_crc(beat[47:16]) == dllp_token) begin
                break;
            end
        end
        beat[15:0] = dllp_token;
        return beat;
    endfunction

    task automatic report_mismatch(input string name, input logic [255:0] want, got);
        errors++;
        $display("ERROR %0t %s expected %0h actual %0h", $time, name, want, got);
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic next_beat(input logic valid, input pipe_data_t beat);
        @(negedge sclk);
        pipe_valid     = valid;
        pipe_data      = beat;
        exp_dllp.an_en = acknak_none;   // pulses last one beat
        exp_dllp.cc_en = '0;
        exp_tlp.fwd    = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) next_beat(1'b0, '0);
    endtask

    task automatic send_dllp(input dllp_type_e kind, input bit corrupt);
        pipe_data_t beat;
        logic [7:0] hdr;
        credit_t    data;
        credit_t    h;
        beat = build_dllp(kind, hdr, data);
        h    = {4'b0, hdr};
        if (dllp_crc(beat[47:16]) != dllp_token) begin
            errors++;
            $display("no payload with a matching crc found for dllp type %0h", kind);
        end
        if (corrupt) begin
            beat[30] = ~beat[30];   // reserved bit, crc breaks
        end
        next_beat(1'b1, beat);
        if (!corrupt) begin
            case (kind)
                dllp_ack: begin
                    exp_dllp.an_en  = acknak_ack;
                    exp_dllp.an_num = data;
                end
                dllp_nak: begin
                    exp_dllp.an_en  = acknak_nak;
                    exp_dllp.an_num = data;
                end
                dllp_init1_p: begin
                    exp_dllp.cl[59:36] = {h, data};
                    exp_dllp.cc_en[2]  = 1'b1;
                    seen1[0]           = 1'b1;
                end
                dllp_init1_np: begin
                    exp_dllp.cl[35:24] = h;
                    exp_dllp.cc_en[1]  = 1'b1;
                    seen1[1]           = 1'b1;
                end
                dllp_init1_cpl: begin
                    exp_dllp.cl[23:0] = {h, data};
                    exp_dllp.cc_en[0] = 1'b1;
                    seen1[2]          = 1'b1;
                end
                dllp_init2_p:   seen2[0] = 1'b1;
                dllp_init2_np:  seen2[1] = 1'b1;
                dllp_init2_cpl: seen2[2] = 1'b1;
                dllp_updfc_p:   exp_dllp.cc[59:36] = {h, data};
                dllp_updfc_np:  exp_dllp.cc[35:24] = h;
                dllp_updfc_cpl: exp_dllp.cc[23:0] = {h, data};
                default: ;
            endcase
            exp_dllp.init = {&seen1, &seen2};
        end
    endtask

    task automatic send_tlp(input seq_num_t seq);
        pipe_data_t beat;
        for (int w = 0; w < 8; w++) begin
            beat[w*32 +: 32] = $urandom;
        end
        beat[3:0]   = np_marker;
        beat[19:16] = seq[11:8];
        beat[31:24] = seq[7:0];
        next_beat(1'b1, beat);
        if (seq == exp_tlp.next_seq) begin
            exp_tlp.next_seq = exp_tlp.next_seq + 12'd1;
            exp_tlp.nak      = 1'b0;
            exp_tlp.fwd      = 1'b1;
            exp_tlp.data     = pipe_data_t'(beat[159:32]);
        end else begin
            exp_tlp.nak = 1'b1;
        end
        idle(4);   // let the checker get back to idle
    endtask

    // ----------------------------------------------------------------------
    // checks against the delayed model
    // ----------------------------------------------------------------------
    a_acknak_en: assert property (@(posedge sclk) disable iff (!srst_n)
            acknak_seq_en_o == dllp_q[3].an_en)
        else report_mismatch("acknak_seq_en_o", 256'($sampled(dllp_q[3].an_en)),
                             256'($sampled(acknak_seq_en_o)));
    a_acknak_num: assert property (@(posedge sclk) disable iff (!srst_n)
            acknak_seq_num_o == dllp_q[3].an_num)
        else report_mismatch("acknak_seq_num_o", 256'($sampled(dllp_q[3].an_num)),
                             256'($sampled(acknak_seq_num_o)));
    a_cc_en: assert property (@(posedge sclk) disable iff (!srst_n)
            {cc_p_en_o, cc_np_en_o, cc_cpl_en_o} == dllp_q[3].cc_en)
        else report_mismatch("cc_*_en_o", 256'($sampled(dllp_q[3].cc_en)),
                             256'($sampled({cc_p_en_o, cc_np_en_o, cc_cpl_en_o})));
    a_cl: assert property (@(posedge sclk) disable iff (!srst_n) cl_all == dllp_q[3].cl)
        else report_mismatch("cl_*_o", 256'($sampled(dllp_q[3].cl)), 256'($sampled(cl_all)));
    a_cc: assert property (@(posedge sclk) disable iff (!srst_n) cc_all == dllp_q[3].cc)
        else report_mismatch("cc_*_o", 256'($sampled(dllp_q[3].cc)), 256'($sampled(cc_all)));
    a_init: assert property (@(posedge sclk) disable iff (!srst_n)
            {init1_received_o, init2_received_o} == dllp_q[3].init)
        else report_mismatch("init*_received_o", 256'($sampled(dllp_q[3].init)),
                             256'($sampled({init1_received_o, init2_received_o})));
    a_next_seq: assert property (@(posedge sclk) disable iff (!srst_n)
            next_rcv_seq_o == tlp_q[2].next_seq)
        else report_mismatch("next_rcv_seq_o", 256'($sampled(tlp_q[2].next_seq)),
                             256'($sampled(next_rcv_seq_o)));
    a_nak: assert property (@(posedge sclk) disable iff (!srst_n)
            nak_scheduled_o == tlp_q[2].nak)
        else report_mismatch("nak_scheduled_o", 256'($sampled(tlp_q[2].nak)),
                             256'($sampled(nak_scheduled_o)));
    a_tl_code: assert property (@(posedge sclk) disable iff (!srst_n)
            dll2tl_data_en_o == want_code)
        else report_mismatch("dll2tl_data_en_o", 256'($sampled(want_code)),
                             256'($sampled(dll2tl_data_en_o)));
    a_tl_data: assert property (@(posedge sclk) disable iff (!srst_n)
            dll2tl_data_o == tlp_q[3].data)
        else report_mismatch("dll2tl_data_o", $sampled(tlp_q[3].data),
                             $sampled(dll2tl_data_o));

    // run is about a hundred cycles, so this only trips on a hang
    always @(posedge sclk) begin
        cycles++;
        if (cycles >= 2000) begin
            $display("timeout, the test did not finish within %0d cycles", cycles);
            $display("errors: %0d", errors);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        void'($urandom(4842));
        srst_n     = 1'b0;
        pipe_valid = 1'b0;
        pipe_data  = '0;
        repeat (4) @(posedge sclk);
        @(negedge sclk);
        srst_n = 1'b1;
        idle(2);
        repeat (3) begin                     // ack and nak with gaps
            send_dllp(dllp_ack, 1'b0);
            idle(1);
            send_dllp(dllp_nak, 1'b0);
        end
        send_dllp(dllp_nak, 1'b0);           // back to back
        send_dllp(dllp_ack, 1'b0);
        send_dllp(dllp_ack, 1'b0);
        idle(3);
        send_dllp(dllp_ack, 1'b1);           // bad crc, nothing moves
        send_dllp(dllp_init1_p, 1'b1);
        send_dllp(dllp_updfc_cpl, 1'b1);
        idle(3);
        send_dllp(dllp_init1_p, 1'b0);
        send_dllp(dllp_init1_np, 1'b0);
        idle(4);                             // init1 still low here
        send_dllp(dllp_init1_cpl, 1'b0);
        idle(1);
        send_dllp(dllp_updfc_p, 1'b0);
        send_dllp(dllp_updfc_np, 1'b0);
        send_dllp(dllp_updfc_cpl, 1'b0);
        idle(3);
        send_dllp(dllp_init2_p, 1'b0);
        send_dllp(dllp_init2_np, 1'b0);
        idle(4);                             // only two init2 types so far
        send_dllp(dllp_init2_cpl, 1'b0);
        idle(3);
        repeat (6) send_tlp(exp_tlp.next_seq);
        send_tlp(exp_tlp.next_seq + seq_num_t'(1 + $urandom_range(0, 500)));
        send_tlp(exp_tlp.next_seq);          // clears the nak flag
        idle(6);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- sources.f
src/dll_pkg.sv
src/tlp_pkg.sv
src/dllp_if.sv
src/rx_framer.sv
src/dllp_decoder.sv
src/tlp_seq_check.sv
src/dll_rx.sv
bench/dll_rx_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= dll_rx_tb
FILE_LIST  ?= sources.f
LOG        ?= sim.log
PASS_MSG   := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf obj_dir $(LOG)
